// ==== verilog/csr_pkg.sv ====
// Shared widths, CSR addresses, opcode and cause encodings and bundles, imported by every CSR block
package csr_pkg;

    localparam int XLEN      = 32;
    localparam int CSR_ADR_W = 12;

    // Machine-mode CSR addresses
    localparam logic [CSR_ADR_W-1:0] CSR_MSTATUS  = 12'h300;
    localparam logic [CSR_ADR_W-1:0] CSR_MISA     = 12'h301;
    localparam logic [CSR_ADR_W-1:0] CSR_MIE      = 12'h304;
    localparam logic [CSR_ADR_W-1:0] CSR_MTVEC    = 12'h305;
    localparam logic [CSR_ADR_W-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADR_W-1:0] CSR_MEPC     = 12'h341;
    localparam logic [CSR_ADR_W-1:0] CSR_MCAUSE   = 12'h342;
    localparam logic [CSR_ADR_W-1:0] CSR_MTVAL    = 12'h343;
    localparam logic [CSR_ADR_W-1:0] CSR_MIP      = 12'h344;
    localparam logic [CSR_ADR_W-1:0] CSR_MHARTID  = 12'hF14;

    // RV32I, base ISA only
    localparam logic [XLEN-1:0] MISA_VALUE = 32'h4000_0100;

    // Implemented bit positions in mstatus and mie/mip
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MIX_MSI_BIT      = 3;
    localparam int MIX_MTI_BIT      = 7;
    localparam int MIX_MEI_BIT      = 11;

    // mtvec bit 1 and mepc bits 1:0 are hardwired to zero
    localparam logic [XLEN-1:0] MTVEC_WMASK = 32'hFFFF_FFFD;
    localparam logic [XLEN-1:0] MEPC_WMASK  = 32'hFFFF_FFFC;

    // Zicsr funct3 field, 0 and 4 are not CSR operations
    typedef enum logic [2:0] {
        FUNCT3_CSR_RW  = 3'd1,
        FUNCT3_CSR_RS  = 3'd2,
        FUNCT3_CSR_RC  = 3'd3,
        FUNCT3_CSR_RWI = 3'd5,
        FUNCT3_CSR_RSI = 3'd6,
        FUNCT3_CSR_RCI = 3'd7
    } funct3_csr_t;

    typedef enum logic [4:0] {
        IRQ_CAUSE_MSI = 5'd3,
        IRQ_CAUSE_MTI = 5'd7,
        IRQ_CAUSE_MEI = 5'd11
    } irq_cause_t;

    typedef enum logic [4:0] {
        EX_CAUSE_INSTR_MISALIGNED = 5'd0,
        EX_CAUSE_ILLEGAL_INSTR    = 5'd2,
        EX_CAUSE_BREAKPOINT       = 5'd3,
        EX_CAUSE_LOAD_MISALIGNED  = 5'd4,
        EX_CAUSE_STORE_MISALIGNED = 5'd6,
        EX_CAUSE_ECALL_M          = 5'd11
    } ex_cause_t;

    typedef struct packed {
        logic msi;
        logic mti;
        logic mei;
    } irq_vec_t;

    typedef struct packed {
        logic            ena;
        logic [XLEN-1:0] src1;
        logic [XLEN-1:0] src2;
    } funit_in_t;

    typedef struct packed {
        logic            rdy;
        logic            err;
        logic [XLEN-1:0] res;
    } funit_out_t;

    typedef struct packed {
        logic [CSR_ADR_W-1:0] adr;
        logic                 we;
        logic [XLEN-1:0]      wdat;
    } csr_acc_t;

    typedef struct packed {
        logic [XLEN-1:0] rdat;
        logic            hit;
        logic            ro;
    } csr_info_t;

    typedef struct packed {
        logic mie;
        logic mpie;
    } mstatus_t;

    typedef struct packed {
        logic            entry;
        logic            mret;
        logic [XLEN-1:0] mepc;
        logic [XLEN-1:0] mcause;
        logic [XLEN-1:0] mtval;
        mstatus_t        status_next;
    } trap_upd_t;

endpackage

// ==== verilog/csr_ctrl.sv ====
// Zicsr opcode decode that turns one functional unit request into a single CSR access
`timescale 1ns/10ps

module csr_ctrl import csr_pkg::*; (
    input  funit_in_t   fu_i,
    input  funct3_csr_t funct_i,
    input  logic        rs1_zero_i,     // rs1 is x0 or uimm is 0
    input  csr_info_t   csr_info_i,
    output csr_acc_t    csr_acc_o,
    output funit_out_t  fu_o
);

    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] old_val;
    logic [XLEN-1:0] new_val;
    logic            wr_req;
    logic            illegal;
    logic            err;

    assign src1    = fu_i.src1;
    assign old_val = csr_info_i.rdat;

    // Write value and write intent per opcode class
    always_comb begin
        new_val = '0;
        wr_req  = 1'b0;
        illegal = 1'b0;

        case (funct_i)
            FUNCT3_CSR_RW,
            FUNCT3_CSR_RWI: begin
                new_val = src1;
                wr_req  = 1'b1;
            end

            FUNCT3_CSR_RS,
            FUNCT3_CSR_RSI: begin
                new_val = old_val | src1;
                wr_req  = !rs1_zero_i;
            end

            FUNCT3_CSR_RC,
            FUNCT3_CSR_RCI: begin
                new_val = old_val & ~src1;
                wr_req  = !rs1_zero_i;
            end

            default: begin
                illegal = 1'b1;
            end
        endcase
    end

    // A set or clear with a zero mask on a read-only CSR is still legal
    assign err = fu_i.ena & (illegal | !csr_info_i.hit | (wr_req & csr_info_i.ro));

    always_comb begin
        csr_acc_o.adr  = fu_i.src2[CSR_ADR_W-1:0];
        csr_acc_o.we   = fu_i.ena & wr_req & !err;
        csr_acc_o.wdat = new_val;
    end

    always_comb begin
        fu_o.rdy = fu_i.ena;
        fu_o.err = err;

        // Old value goes back to rd, nothing on a failed access
        if (fu_i.ena && !err) begin
            fu_o.res = old_val;
        end else begin
            fu_o.res = '0;
        end
    end

endmodule

// ==== verilog/csr_regs.sv ====
// Machine-mode CSR storage with read decode, write masks and trap/mret state updates
`timescale 1ns/10ps

module csr_regs import csr_pkg::*; (
    input  logic            clk_i,
    input  logic            arst_n_i,

    input  csr_acc_t        csr_acc_i,
    output csr_info_t       csr_info_o,

    input  trap_upd_t       trap_upd_i,
    input  irq_vec_t        irq_pend_i,

    output mstatus_t        mstatus_o,
    output irq_vec_t        mie_o,
    output logic [XLEN-1:0] mtvec_o,
    output logic [XLEN-1:0] mepc_o
);

    mstatus_t        mstatus_q;
    irq_vec_t        mie_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mscratch_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] mtval_q;

    logic [XLEN-1:0] wdat;
    assign wdat = csr_acc_i.wdat;

    // Address decode and read mux
    always_comb begin
        csr_info_o.rdat = '0;
        csr_info_o.hit  = 1'b1;
        csr_info_o.ro   = 1'b0;

        case (csr_acc_i.adr)
            CSR_MSTATUS: begin
                csr_info_o.rdat[MSTATUS_MIE_BIT]  = mstatus_q.mie;
                csr_info_o.rdat[MSTATUS_MPIE_BIT] = mstatus_q.mpie;
            end
            CSR_MISA: begin
                csr_info_o.rdat = MISA_VALUE;
                csr_info_o.ro   = 1'b1;
            end
            CSR_MIE: begin
                csr_info_o.rdat[MIX_MSI_BIT] = mie_q.msi;
                csr_info_o.rdat[MIX_MTI_BIT] = mie_q.mti;
                csr_info_o.rdat[MIX_MEI_BIT] = mie_q.mei;
            end
            CSR_MTVEC:    csr_info_o.rdat = mtvec_q;
            CSR_MSCRATCH: csr_info_o.rdat = mscratch_q;
            CSR_MEPC:     csr_info_o.rdat = mepc_q;
            CSR_MCAUSE:   csr_info_o.rdat = mcause_q;
            CSR_MTVAL:    csr_info_o.rdat = mtval_q;
            CSR_MIP: begin
                // Pending lines are wired straight through
                csr_info_o.rdat[MIX_MSI_BIT] = irq_pend_i.msi;
                csr_info_o.rdat[MIX_MTI_BIT] = irq_pend_i.mti;
                csr_info_o.rdat[MIX_MEI_BIT] = irq_pend_i.mei;
                csr_info_o.ro                = 1'b1;
            end
            CSR_MHARTID: begin
                csr_info_o.ro = 1'b1;
            end
            default: begin
                csr_info_o.hit = 1'b0;
            end
        endcase
    end

    // Software writes first, trap events afterwards so they take priority
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mstatus_q  <= '0;
            mie_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
        end else begin
            if (csr_acc_i.we) begin
                case (csr_acc_i.adr)
                    CSR_MSTATUS: begin
                        mstatus_q.mie  <= wdat[MSTATUS_MIE_BIT];
                        mstatus_q.mpie <= wdat[MSTATUS_MPIE_BIT];
                    end
                    CSR_MIE: begin
                        mie_q.msi <= wdat[MIX_MSI_BIT];
                        mie_q.mti <= wdat[MIX_MTI_BIT];
                        mie_q.mei <= wdat[MIX_MEI_BIT];
                    end
                    CSR_MTVEC:    mtvec_q    <= wdat & MTVEC_WMASK;
                    CSR_MSCRATCH: mscratch_q <= wdat;
                    CSR_MEPC:     mepc_q     <= wdat & MEPC_WMASK;
                    CSR_MCAUSE:   mcause_q   <= wdat;
                    CSR_MTVAL:    mtval_q    <= wdat;
                    default: begin
                    end
                endcase
            end

            if (trap_upd_i.entry) begin
                mepc_q    <= trap_upd_i.mepc & MEPC_WMASK;
                mcause_q  <= trap_upd_i.mcause;
                mtval_q   <= trap_upd_i.mtval;
                mstatus_q <= trap_upd_i.status_next;
            end else if (trap_upd_i.mret) begin
                mstatus_q <= trap_upd_i.status_next;
            end
        end
    end

    assign mstatus_o = mstatus_q;
    assign mie_o     = mie_q;
    assign mtvec_o   = mtvec_q;
    assign mepc_o    = mepc_q;

endmodule

// ==== verilog/csr_irq.sv ====
// Interrupt request logic that masks pending lines and picks one cause by fixed priority
`timescale 1ns/10ps

module csr_irq import csr_pkg::*; (
    input  irq_vec_t   irq_pend_i,
    input  irq_vec_t   mie_i,
    input  mstatus_t   mstatus_i,
    output logic       irq_o,
    output irq_cause_t irq_cause_o
);

    irq_vec_t active;

    // Line must be pending, enabled and globally unmasked
    always_comb begin
        active.msi = irq_pend_i.msi & mie_i.msi & mstatus_i.mie;
        active.mti = irq_pend_i.mti & mie_i.mti & mstatus_i.mie;
        active.mei = irq_pend_i.mei & mie_i.mei & mstatus_i.mie;
    end

    assign irq_o = active.msi | active.mti | active.mei;

    // External beats software beats timer
    always_comb begin
        if (active.mei) begin
            irq_cause_o = IRQ_CAUSE_MEI;
        end else if (active.msi) begin
            irq_cause_o = IRQ_CAUSE_MSI;
        end else if (active.mti) begin
            irq_cause_o = IRQ_CAUSE_MTI;
        end else begin
            // Idle value, only meaningful while irq_o is high
            irq_cause_o = IRQ_CAUSE_MSI;
        end
    end

endmodule

// ==== verilog/csr_trap.sv ====
// Trap event arbitration, status stacking and handler address for the CSR unit
`timescale 1ns/10ps

module csr_trap import csr_pkg::*; (
    input  logic            ex_i,
    input  ex_cause_t       ex_cause_i,
    input  logic            irq_take_i,
    input  irq_cause_t      irq_cause_i,
    input  logic            mret_i,
    input  logic [XLEN-1:0] trap_pc_i,
    input  logic [XLEN-1:0] trap_adr_i,
    input  mstatus_t        mstatus_i,
    input  logic [XLEN-1:0] mtvec_i,
    output trap_upd_t       trap_upd_o,
    output logic [XLEN-1:0] trap_vec_o
);

    logic            irq_entry;
    logic [XLEN-1:0] base;

    // Exception first, then interrupt, then mret
    assign irq_entry = irq_take_i & !ex_i;

    always_comb begin
        trap_upd_o             = '0;
        trap_upd_o.status_next = mstatus_i;

        if (ex_i || irq_take_i) begin
            trap_upd_o.entry            = 1'b1;
            trap_upd_o.mepc             = trap_pc_i;
            trap_upd_o.status_next.mpie = mstatus_i.mie;
            trap_upd_o.status_next.mie  = 1'b0;
            if (ex_i) begin
                trap_upd_o.mcause = XLEN'(ex_cause_i);
                trap_upd_o.mtval  = trap_adr_i;
            end else begin
                trap_upd_o.mcause         = XLEN'(irq_cause_i);
                trap_upd_o.mcause[XLEN-1] = 1'b1;
            end
        end else if (mret_i) begin
            trap_upd_o.mret             = 1'b1;
            trap_upd_o.status_next.mie  = mstatus_i.mpie;
            trap_upd_o.status_next.mpie = 1'b1;
        end
    end

    // Mode in bit 0, vectored only applies to interrupts
    assign base       = {mtvec_i[XLEN-1:2], 2'b00};
    assign trap_vec_o = (mtvec_i[0] && irq_entry) ? base + (XLEN'(irq_cause_i) << 2) : base;

endmodule

// ==== verilog/csr_unit.sv ====
// Top of the machine-mode CSR unit, driven by the core's execute stage and trap logic
`timescale 1ns/10ps

module csr_unit import csr_pkg::*; (
    input  logic        clk_i,
    input  logic        arst_n_i,

    // Functional unit port
    input  funit_in_t   fu_i,
    input  funct3_csr_t funct_i,
    input  logic        rs1_zero_i,
    output funit_out_t  fu_o,

    // Interrupt lines and request
    input  irq_vec_t    irq_pend_i,
    output logic        irq_o,
    output irq_cause_t  irq_cause_o,

    // Trap events
    input  logic            ex_i,
    input  ex_cause_t       ex_cause_i,
    input  logic            irq_take_i,
    input  logic            mret_i,
    input  logic [XLEN-1:0] trap_pc_i,
    input  logic [XLEN-1:0] trap_adr_i,
    output logic [XLEN-1:0] trap_vec_o,
    output logic [XLEN-1:0] epc_o
);

    csr_acc_t        csr_acc;
    csr_info_t       csr_info;
    trap_upd_t       trap_upd;
    mstatus_t        mstatus;
    irq_vec_t        mie;
    logic [XLEN-1:0] mtvec;

    csr_ctrl u_ctrl (
        .fu_i       (fu_i),
        .funct_i    (funct_i),
        .rs1_zero_i (rs1_zero_i),
        .csr_info_i (csr_info),
        .csr_acc_o  (csr_acc),
        .fu_o       (fu_o)
    );

    csr_regs u_regs (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .csr_acc_i  (csr_acc),
        .csr_info_o (csr_info),
        .trap_upd_i (trap_upd),
        .irq_pend_i (irq_pend_i),
        .mstatus_o  (mstatus),
        .mie_o      (mie),
        .mtvec_o    (mtvec),
        .mepc_o     (epc_o)
    );

    csr_irq u_irq (
        .irq_pend_i  (irq_pend_i),
        .mie_i       (mie),
        .mstatus_i   (mstatus),
        .irq_o       (irq_o),
        .irq_cause_o (irq_cause_o)
    );

    csr_trap u_trap (
        .ex_i        (ex_i),
        .ex_cause_i  (ex_cause_i),
        .irq_take_i  (irq_take_i),
        .irq_cause_i (irq_cause_o),
        .mret_i      (mret_i),
        .trap_pc_i   (trap_pc_i),
        .trap_adr_i  (trap_adr_i),
        .mstatus_i   (mstatus),
        .mtvec_i     (mtvec),
        .trap_upd_o  (trap_upd),
        .trap_vec_o  (trap_vec_o)
    );

endmodule

// ==== dv/csr_unit_tb.sv ====
// Self-checking testbench for the CSR unit, run with the file list, compares against a shadow model
`timescale 1ns/10ps

module csr_unit_tb import csr_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int N_DIRECTED = 80;
    localparam int N_RANDOM   = 400;
    localparam int TIMEOUT_NS = (N_DIRECTED + N_RANDOM + 50) * CLK_PERIOD;

    logic            clk_i;
    logic            arst_n_i;
    funit_in_t       fu_i;
    funct3_csr_t     funct_i;
    logic            rs1_zero_i;
    funit_out_t      fu_o;
    irq_vec_t        irq_pend_i;
    logic            irq_o;
    irq_cause_t      irq_cause_o;
    logic            ex_i;
    ex_cause_t       ex_cause_i;
    logic            irq_take_i;
    logic            mret_i;
    logic [XLEN-1:0] trap_pc_i;
    logic [XLEN-1:0] trap_adr_i;
    logic [XLEN-1:0] trap_vec_o;
    logic [XLEN-1:0] epc_o;

    // Shadow model of the CSR state
    logic            m_mie;
    logic            m_mpie;
    irq_vec_t        m_en;
    logic [XLEN-1:0] m_mtvec;
    logic [XLEN-1:0] m_mscratch;
    logic [XLEN-1:0] m_mepc;
    logic [XLEN-1:0] m_mcause;
    logic [XLEN-1:0] m_mtval;
    irq_vec_t        pend_drv;
    int unsigned     rnd_seed;

    // Last entry is unmapped
    logic [CSR_ADR_W-1:0] adr_list [11] = '{CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC,
        CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP, CSR_MHARTID, 12'h7C0};
    ex_cause_t ex_list [6] = '{EX_CAUSE_INSTR_MISALIGNED, EX_CAUSE_ILLEGAL_INSTR,
        EX_CAUSE_BREAKPOINT, EX_CAUSE_LOAD_MISALIGNED, EX_CAUSE_STORE_MISALIGNED,
        EX_CAUSE_ECALL_M};

    csr_unit u_dut (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .fu_i        (fu_i),
        .funct_i     (funct_i),
        .rs1_zero_i  (rs1_zero_i),
        .fu_o        (fu_o),
        .irq_pend_i  (irq_pend_i),
        .irq_o       (irq_o),
        .irq_cause_o (irq_cause_o),
        .ex_i        (ex_i),
        .ex_cause_i  (ex_cause_i),
        .irq_take_i  (irq_take_i),
        .mret_i      (mret_i),
        .trap_pc_i   (trap_pc_i),
        .trap_adr_i  (trap_adr_i),
        .trap_vec_o  (trap_vec_o),
        .epc_o       (epc_o)
    );

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired, the tests did not finish in time");
        $display("Something failed");
        $fatal(1);
    end

    task automatic report_mismatch(input string test, input string what,
                                   input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
        $display("Error: %s %s expected %h actual %h", test, what, exp, act);
        $display("Something failed");
        $fatal(1);
    endtask

    function automatic logic csr_mapped(input logic [CSR_ADR_W-1:0] adr);
        for (int i = 0; i < 10; i++) begin
            if (adr_list[i] == adr) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic csr_read_only(input logic [CSR_ADR_W-1:0] adr);
        return adr == CSR_MISA || adr == CSR_MIP || adr == CSR_MHARTID;
    endfunction

    function automatic logic [XLEN-1:0] model_read(input logic [CSR_ADR_W-1:0] adr);
        logic [XLEN-1:0] r;
        r = '0;
        case (adr)
            CSR_MSTATUS: begin
                r[3] = m_mie;
                r[7] = m_mpie;
            end
            CSR_MISA:     r = MISA_VALUE;
            CSR_MIE:      r = {20'h0, m_en.mei, 3'h0, m_en.mti, 3'h0, m_en.msi, 3'h0};
            CSR_MTVEC:    r = m_mtvec;
            CSR_MSCRATCH: r = m_mscratch;
            CSR_MEPC:     r = m_mepc;
            CSR_MCAUSE:   r = m_mcause;
            CSR_MTVAL:    r = m_mtval;
            CSR_MIP:      r = {20'h0, irq_pend_i.mei, 3'h0, irq_pend_i.mti, 3'h0,
                               irq_pend_i.msi, 3'h0};
            default:      r = '0;
        endcase
        return r;
    endfunction

    function automatic logic irq_active();
        return m_mie && |(irq_pend_i & m_en);
    endfunction

    // External over software over timer
    function automatic logic [4:0] irq_pick();
        if (irq_pend_i.mei && m_en.mei) return 5'd11;
        if (irq_pend_i.msi && m_en.msi) return 5'd3;
        return 5'd7;
    endfunction

    task automatic write_model(input logic [CSR_ADR_W-1:0] adr, input logic [XLEN-1:0] d);
        case (adr)
            CSR_MSTATUS: begin
                m_mie  = d[3];
                m_mpie = d[7];
            end
            CSR_MIE:      m_en       = {d[3], d[7], d[11]};
            CSR_MTVEC:    m_mtvec    = d & 32'hFFFF_FFFD;
            CSR_MSCRATCH: m_mscratch = d;
            CSR_MEPC:     m_mepc     = d & 32'hFFFF_FFFC;
            CSR_MCAUSE:   m_mcause   = d;
            CSR_MTVAL:    m_mtval    = d;
            default: ;
        endcase
    endtask

    // Inputs were driven on the falling edge, check mid cycle, update model at the rising edge
    task automatic run_cycle(input string name);
        logic [CSR_ADR_W-1:0] adr;
        logic [XLEN-1:0]      old_val;
        logic [XLEN-1:0]      new_val;
        logic [XLEN-1:0]      exp_res;
        logic [XLEN-1:0]      exp_vec;
        logic                 wr_req;
        logic                 exp_err;
        logic                 exp_irq;
        logic                 cur_mie;
        logic                 cur_mpie;
        logic [4:0]           cause;
        int                   f;
        #(CLK_PERIOD/4);
        adr     = fu_i.src2[CSR_ADR_W-1:0];
        f       = int'(funct_i);
        old_val = model_read(adr);
        new_val = fu_i.src1;
        wr_req  = f[1:0] == 2'd1 || !rs1_zero_i;
        if (f[1:0] == 2'd2) new_val = old_val | fu_i.src1;
        if (f[1:0] == 2'd3) new_val = old_val & ~fu_i.src1;
        exp_err = fu_i.ena && (f[1:0] == 2'd0 || !csr_mapped(adr) ||
                               (wr_req && csr_read_only(adr)));
        exp_res = (fu_i.ena && !exp_err) ? old_val : '0;
        assert (fu_o.rdy == fu_i.ena) else report_mismatch(name, "rdy", fu_i.ena, fu_o.rdy);
        assert (fu_o.err == exp_err) else report_mismatch(name, "err", exp_err, fu_o.err);
        assert (fu_o.res == exp_res) else report_mismatch(name, "res", exp_res, fu_o.res);
        exp_irq = irq_active();
        cause   = irq_pick();
        assert (irq_o == exp_irq) else report_mismatch(name, "irq", exp_irq, irq_o);
        if (exp_irq) begin
            assert (irq_cause_o == cause)
                else report_mismatch(name, "irq cause", cause, irq_cause_o);
        end
        exp_vec = m_mtvec & 32'hFFFF_FFFC;
        if (m_mtvec[0] && irq_take_i && !ex_i) exp_vec = exp_vec + 4 * cause;
        assert (trap_vec_o == exp_vec) else report_mismatch(name, "trap_vec", exp_vec, trap_vec_o);
        assert (epc_o == m_mepc) else report_mismatch(name, "epc", m_mepc, epc_o);
        @(posedge clk_i);
        cur_mie  = m_mie;
        cur_mpie = m_mpie;
        if (fu_i.ena && wr_req && !exp_err) write_model(adr, new_val);
        if (ex_i || irq_take_i) begin
            m_mepc   = trap_pc_i & 32'hFFFF_FFFC;
            m_mcause = ex_i ? XLEN'(ex_cause_i) : (32'h8000_0000 | cause);
            m_mtval  = ex_i ? trap_adr_i : '0;
            m_mpie   = cur_mie;
            m_mie    = 1'b0;
        end else if (mret_i) begin
            m_mie  = cur_mpie;
            m_mpie = 1'b1;
        end
    endtask

    task automatic start_cycle();
        @(negedge clk_i);
        irq_pend_i = pend_drv;
        fu_i       = '0;
        rs1_zero_i = 1'b0;
        ex_i       = 1'b0;
        irq_take_i = 1'b0;
        mret_i     = 1'b0;
    endtask

    task automatic set_op(input int f, input logic [CSR_ADR_W-1:0] adr,
                          input logic [XLEN-1:0] src1, input logic rs1z);
        fu_i.ena   = 1'b1;
        fu_i.src1  = src1;
        fu_i.src2  = XLEN'(adr);
        funct_i    = funct3_csr_t'(f);
        rs1_zero_i = rs1z;
    endtask

    task automatic set_trap(input logic ex, input ex_cause_t cause, input logic take,
                            input logic ret, input logic [XLEN-1:0] pc,
                            input logic [XLEN-1:0] tadr);
        ex_i       = ex;
        ex_cause_i = cause;
        irq_take_i = take;
        mret_i     = ret;
        trap_pc_i  = pc;
        trap_adr_i = tadr;
    endtask

    task automatic csr_op(input string name, input int f, input logic [CSR_ADR_W-1:0] adr,
                          input logic [XLEN-1:0] src1, input logic rs1z);
        start_cycle();
        set_op(f, adr, src1, rs1z);
        run_cycle(name);
    endtask

    task automatic read_csr(input string name, input logic [CSR_ADR_W-1:0] adr);
        csr_op(name, FUNCT3_CSR_RS, adr, '0, 1'b1);
    endtask

    task automatic trap_op(input string name, input logic ex, input ex_cause_t cause,
                           input logic take, input logic ret, input logic [XLEN-1:0] pc,
                           input logic [XLEN-1:0] tadr);
        start_cycle();
        set_trap(ex, cause, take, ret, pc, tadr);
        run_cycle(name);
    endtask

    initial begin
        int              sel;
        int              f;
        int              roll;
        logic [XLEN-1:0] src;
        rnd_seed = 32'h0d5f_d3b7;
        void'($urandom(rnd_seed));
        clk_i      = 1'b0;
        arst_n_i   = 1'b0;
        fu_i       = '0;
        funct_i    = FUNCT3_CSR_RW;
        rs1_zero_i = 1'b0;
        pend_drv   = '0;
        irq_pend_i = '0;
        set_trap(1'b0, EX_CAUSE_ILLEGAL_INSTR, 1'b0, 1'b0, '0, '0);
        {m_mie, m_mpie, m_en} = '0;
        {m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval} = '0;
        repeat (2) @(posedge clk_i);
        assert (fu_o.rdy == 1'b0 && fu_o.err == 1'b0 && irq_o == 1'b0)
            else report_mismatch("reset", "rdy/err/irq", '0, {fu_o.rdy, fu_o.err, irq_o});
        @(negedge clk_i);
        arst_n_i = 1'b1;

        start_cycle();
        run_cycle("idle");
        for (int i = 0; i < 10; i++) read_csr("reset values", adr_list[i]);

        csr_op("rw mscratch", FUNCT3_CSR_RW, CSR_MSCRATCH, 32'hDEAD_BEEF, 1'b0);
        csr_op("rwi mscratch", FUNCT3_CSR_RWI, CSR_MSCRATCH, 32'h1F, 1'b0);
        csr_op("rw mtvec", FUNCT3_CSR_RW, CSR_MTVEC, 32'h1234_567F, 1'b0);
        read_csr("mtvec mask", CSR_MTVEC);
        csr_op("rw mepc", FUNCT3_CSR_RW, CSR_MEPC, 32'h8000_0007, 1'b0);
        read_csr("mepc mask", CSR_MEPC);
        csr_op("rw mie", FUNCT3_CSR_RW, CSR_MIE, 32'hFFFF_FFFF, 1'b0);
        read_csr("mie mask", CSR_MIE);
        csr_op("rwi mie", FUNCT3_CSR_RWI, CSR_MIE, 32'h0, 1'b1);

        csr_op("rs mscratch", FUNCT3_CSR_RS, CSR_MSCRATCH, 32'h0000_F0F0, 1'b0);
        csr_op("rc mscratch", FUNCT3_CSR_RC, CSR_MSCRATCH, 32'h0000_00FF, 1'b0);
        csr_op("rsi mscratch", FUNCT3_CSR_RSI, CSR_MSCRATCH, 32'h15, 1'b0);
        csr_op("rci mscratch", FUNCT3_CSR_RCI, CSR_MSCRATCH, 32'h01, 1'b0);
        csr_op("rs no write", FUNCT3_CSR_RS, CSR_MSCRATCH, 32'h0000_FFFF, 1'b1);
        csr_op("rc no write", FUNCT3_CSR_RC, CSR_MSCRATCH, 32'hFFFF_FFFF, 1'b1);
        csr_op("rs misa x0", FUNCT3_CSR_RS, CSR_MISA, '0, 1'b1);
        read_csr("set clear result", CSR_MSCRATCH);

        csr_op("funct 0", 0, CSR_MSCRATCH, 32'h1, 1'b0);
        csr_op("funct 4", 4, CSR_MSCRATCH, 32'h1, 1'b0);
        csr_op("unmapped", FUNCT3_CSR_RW, 12'h7C0, 32'h1, 1'b0);
        csr_op("write mip", FUNCT3_CSR_RW, CSR_MIP, 32'h888, 1'b0);
        csr_op("write misa", FUNCT3_CSR_RW, CSR_MISA, 32'h0, 1'b0);
        csr_op("write mhartid", FUNCT3_CSR_RW, CSR_MHARTID, 32'h1, 1'b0);
        csr_op("set misa", FUNCT3_CSR_RS, CSR_MISA, 32'h1, 1'b0);
        read_csr("after errors", CSR_MSCRATCH);

        pend_drv = 3'b111;
        read_csr("mip all", CSR_MIP);
        csr_op("enable lines", FUNCT3_CSR_RW, CSR_MIE, 32'h888, 1'b0);
        csr_op("global enable", FUNCT3_CSR_RS, CSR_MSTATUS, 32'h8, 1'b0);
        pend_drv = 3'b110;
        read_csr("msi over mti", CSR_MIP);
        pend_drv = 3'b010;
        read_csr("mti alone", CSR_MIP);

        csr_op("direct mtvec", FUNCT3_CSR_RW, CSR_MTVEC, 32'h0000_0100, 1'b0);
        trap_op("exception", 1'b1, EX_CAUSE_ILLEGAL_INSTR, 1'b0, 1'b0,
                32'h2000_0006, 32'h0000_BAD0);
        read_csr("ex mcause", CSR_MCAUSE);
        read_csr("ex mtval", CSR_MTVAL);
        read_csr("ex mstatus", CSR_MSTATUS);
        trap_op("mret", 1'b0, EX_CAUSE_ILLEGAL_INSTR, 1'b0, 1'b1, '0, '0);
        read_csr("mret mstatus", CSR_MSTATUS);
        csr_op("vectored mtvec", FUNCT3_CSR_RW, CSR_MTVEC, 32'h0000_0201, 1'b0);
        pend_drv = 3'b001;
        trap_op("take irq", 1'b0, EX_CAUSE_ILLEGAL_INSTR, 1'b1, 1'b0,
                32'h3000_0010, 32'hFFFF_FFFF);
        read_csr("irq mcause", CSR_MCAUSE);
        read_csr("irq mtval", CSR_MTVAL);
        trap_op("irq mret", 1'b0, EX_CAUSE_ILLEGAL_INSTR, 1'b0, 1'b1, '0, '0);
        trap_op("vectored ex", 1'b1, EX_CAUSE_ECALL_M, 1'b0, 1'b0, 32'h4000_0020, 32'h0);
        start_cycle();
        set_op(FUNCT3_CSR_RW, CSR_MEPC, 32'h5555_5554, 1'b0);
        set_trap(1'b1, EX_CAUSE_BREAKPOINT, 1'b0, 1'b0, 32'h6000_0008, 32'h0);
        run_cycle("trap beats write");
        read_csr("mepc after race", CSR_MEPC);

        repeat (N_RANDOM) begin
            sel      = $urandom_range(10, 0);
            f        = $urandom_range(7, 0);
            src      = $urandom;
            roll     = $urandom_range(15, 0);
            pend_drv = 3'($urandom);
            if (f >= 5) src = src & 32'h1F;
            start_cycle();
            set_op(f, adr_list[sel], src, src == '0);
            if (roll == 0) begin
                set_trap(1'b1, ex_list[$urandom_range(5, 0)], 1'b0, 1'b0, $urandom, $urandom);
            end else if (roll == 1 && irq_active()) begin
                set_trap(1'b0, EX_CAUSE_ILLEGAL_INSTR, 1'b1, 1'b0, $urandom, '0);
            end else if (roll == 2) begin
                set_trap(1'b0, EX_CAUSE_ILLEGAL_INSTR, 1'b0, 1'b1, '0, '0);
            end
            run_cycle("random");
        end

        start_cycle();
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== csr_unit.f ====
verilog/csr_pkg.sv
verilog/csr_ctrl.sv
verilog/csr_regs.sv
verilog/csr_irq.sv
verilog/csr_trap.sv
verilog/csr_unit.sv
dv/csr_unit_tb.sv
